// File: tb.f
logic/ooo_pkg.sv
logic/issue.sv
logic/alu_rs.sv
logic/mul_rs.sv
logic/rob.sv
logic/regfile_scoreboard.sv
logic/cpu.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// File: tb/tb_cpu.sv
`default_nettype none

module tb_cpu;

  localparam int NUM_INSTR      = 24;
  localparam int MUL_LATENCY    = 3;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * (MUL_LATENCY + 8) + 50;

  logic              clk;
  logic              rst_n;
  logic              instr_valid;
  ooo_pkg::instr_t   instr;
  logic              instr_stall;
  ooo_pkg::commit_t  commit;
  ooo_pkg::reg_idx_t exp_rd;
  ooo_pkg::word_t    exp_value;
  int                checked;
  int                cycles;

  // stimulus table with hand-computed results
  ooo_pkg::instr_t   prog      [NUM_INSTR];
  ooo_pkg::reg_idx_t exp_rds   [NUM_INSTR];
  ooo_pkg::word_t    exp_vals  [NUM_INSTR];
  // idle cycles after each entry, negative for a random gap
  int                gap_after [NUM_INSTR];

  cpu #(
    .ALU_RS_DEPTH(4),
    .MUL_RS_DEPTH(2),
    .MUL_LATENCY (MUL_LATENCY)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_valid(instr_valid),
    .instr      (instr),
    .instr_stall(instr_stall),
    .commit     (commit)
  );

  cpu_checker #(
    .NUM_INSTR(NUM_INSTR)
  ) chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_valid(instr_valid),
    .instr_stall(instr_stall),
    .exp_rd     (exp_rd),
    .exp_value  (exp_value),
    .commit     (commit),
    .checked    (checked)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  function automatic ooo_pkg::instr_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                             input ooo_pkg::reg_idx_t rd,
                                             input ooo_pkg::reg_idx_t rs1,
                                             input ooo_pkg::reg_idx_t rs2);
    ooo_pkg::instr_t i;
    i.opcode = 7'b0110011;
    i.rd     = rd;
    i.rs1    = rs1;
    i.rs2    = rs2;
    i.funct3 = f3;
    i.funct7 = f7;
    i.imm    = '0;
    return i;
  endfunction

  function automatic ooo_pkg::instr_t imm_op(input logic [2:0] f3, input ooo_pkg::reg_idx_t rd,
                                             input ooo_pkg::reg_idx_t rs1,
                                             input ooo_pkg::word_t imm);
    ooo_pkg::instr_t i;
    i.opcode = 7'b0010011;
    i.rd     = rd;
    i.rs1    = rs1;
    i.rs2    = '0;
    i.funct3 = f3;
    i.funct7 = '0;
    i.imm    = imm;
    return i;
  endfunction

  task automatic put_entry(input int k, input ooo_pkg::instr_t i, input ooo_pkg::reg_idx_t rd,
                           input ooo_pkg::word_t val, input int gap);
    prog[k]      = i;
    exp_rds[k]   = rd;
    exp_vals[k]  = val;
    gap_after[k] = gap;
  endtask

  task automatic load_table();
    put_entry(0,  imm_op(3'b000, 5'd1, 5'd0, 32'd5), 5'd1, 32'h0000_0005, -1);
    // one idle cycle puts the consumer on the producer's broadcast
    put_entry(1,  imm_op(3'b000, 5'd2, 5'd0, 32'd12), 5'd2, 32'h0000_000c, 1);
    put_entry(2,  reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0011, -1);
    put_entry(3,  reg_op(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 5'd4, 32'h0000_0007, -1);
    put_entry(4,  reg_op(7'h00, 3'b100, 5'd5, 5'd1, 5'd2), 5'd5, 32'h0000_0009, -1);
    put_entry(5,  reg_op(7'h00, 3'b110, 5'd6, 5'd3, 5'd4), 5'd6, 32'h0000_0017, -1);
    put_entry(6,  reg_op(7'h00, 3'b111, 5'd7, 5'd6, 5'd5), 5'd7, 32'h0000_0001, -1);
    // burst: two muls wait on one product, mul station fills
    put_entry(7,  reg_op(7'h00, 3'b001, 5'd8, 5'd7, 5'd2), 5'd8, 32'h0000_1000, 0);
    put_entry(8,  reg_op(7'h01, 3'b000, 5'd9, 5'd8, 5'd2), 5'd9, 32'h0000_c000, 0);
    put_entry(9,  imm_op(3'b000, 5'd10, 5'd1, 32'hffff_ffff), 5'd10, 32'h0000_0004, 0);
    put_entry(10, reg_op(7'h00, 3'b010, 5'd11, 5'd4, 5'd1), 5'd11, 32'h0000_0000, 0);
    put_entry(11, reg_op(7'h01, 3'b000, 5'd12, 5'd9, 5'd9), 5'd12, 32'h9000_0000, 0);
    put_entry(12, reg_op(7'h01, 3'b000, 5'd13, 5'd12, 5'd2), 5'd13, 32'hc000_0000, 0);
    put_entry(13, reg_op(7'h01, 3'b000, 5'd14, 5'd12, 5'd1), 5'd14, 32'hd000_0000, 0);
    put_entry(14, reg_op(7'h00, 3'b000, 5'd15, 5'd14, 5'd13), 5'd15, 32'h9000_0000, -1);
    // x0 as destination and as source
    put_entry(15, imm_op(3'b000, 5'd0, 5'd1, 32'd100), 5'd0, 32'h0000_0069, 0);
    put_entry(16, reg_op(7'h00, 3'b000, 5'd16, 5'd0, 5'd1), 5'd16, 32'h0000_0005, 0);
    put_entry(17, reg_op(7'h01, 3'b000, 5'd0, 5'd2, 5'd2), 5'd0, 32'h0000_0090, 0);
    put_entry(18, reg_op(7'h00, 3'b110, 5'd17, 5'd0, 5'd0), 5'd17, 32'h0000_0000, -1);
    put_entry(19, reg_op(7'h00, 3'b101, 5'd18, 5'd14, 5'd7), 5'd18, 32'h6800_0000, -1);
    put_entry(20, imm_op(3'b000, 5'd19, 5'd18, 32'hffff_fff0), 5'd19, 32'h67ff_fff0, -1);
    put_entry(21, reg_op(7'h20, 3'b000, 5'd20, 5'd16, 5'd4), 5'd20, 32'hffff_fffe, -1);
    put_entry(22, reg_op(7'h00, 3'b010, 5'd21, 5'd20, 5'd16), 5'd21, 32'h0000_0001, -1);
    put_entry(23, reg_op(7'h01, 3'b000, 5'd22, 5'd20, 5'd20), 5'd22, 32'h0000_0004, -1);
  endtask

  // starts and ends on a falling edge, holds each instruction while stalled
  task automatic send_program();
    int gap;
    for (int k = 0; k < NUM_INSTR; k++) begin
      instr_valid = 1'b1;
      instr       = prog[k];
      exp_rd      = exp_rds[k];
      exp_value   = exp_vals[k];
      @(posedge clk);
      while (instr_stall) begin
        @(posedge clk);
      end
      @(negedge clk);
      instr_valid = 1'b0;
      gap = (gap_after[k] < 0) ? $urandom_range(2, 0) : gap_after[k];
      repeat (gap) @(negedge clk);
    end
  endtask

  initial begin
    int unsigned seed_val;
    int          total_errors;
    bit          timed_out;
    seed_val    = $urandom(32'h9125);
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_rd      = '0;
    exp_value   = '0;
    cycles      = 0;
    load_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      send_program();
    join_none
    while (checked < NUM_INSTR && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
    end
    timed_out = (checked < NUM_INSTR);
    chk_i.report(timed_out, total_errors);
    if (timed_out || total_errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule : tb_cpu

`default_nettype wire

// File: tb/cpu_checker.sv
`default_nettype none

module cpu_checker #(
  parameter int NUM_INSTR = 24
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  logic              instr_stall,
  input  ooo_pkg::reg_idx_t exp_rd,
  input  ooo_pkg::word_t    exp_value,
  input  ooo_pkg::commit_t  commit,
  output int                checked
);

  typedef struct packed {
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::word_t    value;
  } expect_t;

  expect_t pending_q [$];
  int      errors;
  int      next_order;
  int      stall_cycles;

  task automatic compare_commit();
    expect_t exp;
    logic    bad;
    bad = 1'b0;
    if (pending_q.size() == 0) begin
      $display("commit of rd x%0d arrived with no instruction outstanding", commit.rd);
      errors++;
    end else begin
      exp = pending_q.pop_front();
      if (commit.order != ooo_pkg::order_t'(next_order)) begin
        $display("ERROR order %0d commit.order: got %04h expected %04h",
                 next_order, commit.order, ooo_pkg::order_t'(next_order));
        bad = 1'b1;
      end
      if (commit.rd != exp.rd) begin
        $display("ERROR order %0d commit.rd: got %02h expected %02h",
                 next_order, commit.rd, exp.rd);
        bad = 1'b1;
      end
      if (commit.value != exp.value) begin
        $display("ERROR order %0d commit.value: got %08h expected %08h",
                 next_order, commit.value, exp.value);
        bad = 1'b1;
      end
      if (bad) begin
        errors++;
      end else begin
        $display("order %0d: rd x%0d = %08h ok", next_order, commit.rd, commit.value);
      end
    end
    next_order++;
    checked++;
  endtask

  // accepted instructions queue their expected result in program order
  always @(posedge clk) begin
    if (rst_n) begin
      if (commit.valid) begin
        compare_commit();
      end
      if (instr_valid && instr_stall) begin
        stall_cycles++;
      end
      if (instr_valid && !instr_stall) begin
        pending_q.push_back({exp_rd, exp_value});
      end
    end
  end

  task automatic report(input bit timed_out, output int total_errors);
    int missing;
    missing = NUM_INSTR - checked;
    if (timed_out) begin
      $display("timeout: %0d of %0d instructions never committed", missing, NUM_INSTR);
      for (int k = checked; k < NUM_INSTR; k++) begin
        $display("order %0d never committed", k);
      end
    end
    if (stall_cycles == 0) begin
      $display("instr_stall never rose while an instruction was waiting");
      errors++;
    end
    $display("commits checked %0d, errors %0d, missing %0d, stall cycles %0d",
             checked, errors, missing, stall_cycles);
    total_errors = errors + missing;
  endtask

endmodule : cpu_checker

`default_nettype wire

// File: logic/cpu.sv
`default_nettype none

module cpu #(
  parameter int ALU_RS_DEPTH = 4,
  parameter int MUL_RS_DEPTH = 2,
  parameter int MUL_LATENCY  = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  ooo_pkg::instr_t    instr,
  output logic               instr_stall,
  output ooo_pkg::commit_t   commit
);

  // issue control
  logic              alu_full;
  logic              mul_full;
  logic              rob_full;
  logic              alu_issue;
  logic              mul_issue;
  logic              rob_push;
  ooo_pkg::alu_op_e  op;
  logic              use_imm;

  // rename and operand lookup
  ooo_pkg::rob_tag_t alloc_tag;
  ooo_pkg::rob_tag_t rs1_tag;
  ooo_pkg::rob_tag_t rs2_tag;
  logic              rs1_done;
  logic              rs2_done;
  ooo_pkg::word_t    rs1_val;
  ooo_pkg::word_t    rs2_val;
  ooo_pkg::rob_tag_t commit_tag;
  ooo_pkg::operand_t src1;
  ooo_pkg::operand_t src2;
  ooo_pkg::dispatch_t disp;

  ooo_pkg::cdb_t     alu_lane;
  ooo_pkg::cdb_t     mul_lane;
  ooo_pkg::cdb_t     cdb [ooo_pkg::CDB_LANES];

  always_comb begin
    disp.op      = op;
    disp.use_imm = use_imm;
    disp.imm     = instr.imm;
    disp.src1    = src1;
    disp.src2    = src2;
    disp.dest    = alloc_tag;
  end

  // lane 0 alu, lane 1 multiplier
  always_comb begin
    cdb[0] = alu_lane;
    cdb[1] = mul_lane;
  end

  issue issue (
    .instr_valid(instr_valid),
    .instr      (instr),
    .alu_full   (alu_full),
    .mul_full   (mul_full),
    .rob_full   (rob_full),
    .instr_stall(instr_stall),
    .alu_issue  (alu_issue),
    .mul_issue  (mul_issue),
    .rob_push   (rob_push),
    .op         (op),
    .use_imm    (use_imm)
  );

  alu_rs #(
    .ALU_RS_DEPTH(ALU_RS_DEPTH)
  ) alu_rs (
    .clk      (clk),
    .rst_n    (rst_n),
    .alu_issue(alu_issue),
    .disp     (disp),
    .cdb      (cdb),
    .alu_full (alu_full),
    .lane     (alu_lane)
  );

  mul_rs #(
    .MUL_RS_DEPTH(MUL_RS_DEPTH),
    .MUL_LATENCY (MUL_LATENCY)
  ) mul_rs (
    .clk      (clk),
    .rst_n    (rst_n),
    .mul_issue(mul_issue),
    .disp     (disp),
    .cdb      (cdb),
    .mul_full (mul_full),
    .lane     (mul_lane)
  );

  rob rob (
    .clk       (clk),
    .rst_n     (rst_n),
    .rob_push  (rob_push),
    .push_rd   (instr.rd),
    .cdb       (cdb),
    .rs1_tag   (rs1_tag),
    .rs2_tag   (rs2_tag),
    .rob_full  (rob_full),
    .alloc_tag (alloc_tag),
    .rs1_done  (rs1_done),
    .rs1_val   (rs1_val),
    .rs2_done  (rs2_done),
    .rs2_val   (rs2_val),
    .commit    (commit),
    .commit_tag(commit_tag)
  );

  regfile_scoreboard regfile_scoreboard (
    .clk       (clk),
    .rst_n     (rst_n),
    .rob_push  (rob_push),
    .instr     (instr),
    .alloc_tag (alloc_tag),
    .cdb       (cdb),
    .rs1_done  (rs1_done),
    .rs1_val   (rs1_val),
    .rs2_done  (rs2_done),
    .rs2_val   (rs2_val),
    .commit    (commit),
    .commit_tag(commit_tag),
    .rs1_tag   (rs1_tag),
    .rs2_tag   (rs2_tag),
    .src1      (src1),
    .src2      (src2)
  );

endmodule : cpu

`default_nettype wire

// File: logic/regfile_scoreboard.sv
`default_nettype none

module regfile_scoreboard (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rob_push,
  input  ooo_pkg::instr_t   instr,
  input  ooo_pkg::rob_tag_t alloc_tag,
  input  ooo_pkg::cdb_t     cdb [ooo_pkg::CDB_LANES],
  input  logic              rs1_done,
  input  ooo_pkg::word_t    rs1_val,
  input  logic              rs2_done,
  input  ooo_pkg::word_t    rs2_val,
  input  ooo_pkg::commit_t  commit,
  input  ooo_pkg::rob_tag_t commit_tag,
  output ooo_pkg::rob_tag_t rs1_tag,
  output ooo_pkg::rob_tag_t rs2_tag,
  output ooo_pkg::operand_t src1,
  output ooo_pkg::operand_t src2
);

  ooo_pkg::word_t    regs [32];
  logic [31:0]       pend;
  ooo_pkg::rob_tag_t tags [32];

  // register value, else finished rob entry, else same-cycle broadcast
  function automatic ooo_pkg::operand_t lookup(input logic pending,
                                               input ooo_pkg::rob_tag_t tag,
                                               input ooo_pkg::word_t regval,
                                               input logic rob_done,
                                               input ooo_pkg::word_t rob_val,
                                               input ooo_pkg::cdb_t lanes [ooo_pkg::CDB_LANES]);
    ooo_pkg::operand_t o;
    o.ready = 1'b1;
    o.tag   = tag;
    o.value = regval;
    if (pending) begin
      o.ready = rob_done;
      o.value = rob_val;
      o       = ooo_pkg::wake_operand(o, lanes);
    end
    return o;
  endfunction

  assign rs1_tag = tags[instr.rs1];
  assign rs2_tag = tags[instr.rs2];

  assign src1 = lookup(pend[instr.rs1], rs1_tag, regs[instr.rs1], rs1_done, rs1_val, cdb);
  assign src2 = lookup(pend[instr.rs2], rs2_tag, regs[instr.rs2], rs2_done, rs2_val, cdb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (commit.valid && commit.rd != '0) begin
        regs[commit.rd] <= commit.value;
        // a younger rename keeps the register pending
        if (tags[commit.rd] == commit_tag) begin
          pend[commit.rd] <= 1'b0;
        end
      end
      if (rob_push && instr.rd != '0) begin
        pend[instr.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rob_push && instr.rd != '0) begin
      tags[instr.rd] <= alloc_tag;
    end
  end

endmodule : regfile_scoreboard

`default_nettype wire

// File: logic/rob.sv
`default_nettype none

module rob (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rob_push,
  input  ooo_pkg::reg_idx_t push_rd,
  input  ooo_pkg::cdb_t     cdb [ooo_pkg::CDB_LANES],
  input  ooo_pkg::rob_tag_t rs1_tag,
  input  ooo_pkg::rob_tag_t rs2_tag,
  output logic              rob_full,
  output ooo_pkg::rob_tag_t alloc_tag,
  output logic              rs1_done,
  output ooo_pkg::word_t    rs1_val,
  output logic              rs2_done,
  output ooo_pkg::word_t    rs2_val,
  output ooo_pkg::commit_t  commit,
  output ooo_pkg::rob_tag_t commit_tag
);

  localparam int DEPTH = 2 ** $bits(ooo_pkg::rob_tag_t);

  logic [DEPTH-1:0]    valid;
  logic [DEPTH-1:0]    done;
  ooo_pkg::reg_idx_t   rd    [DEPTH];
  ooo_pkg::word_t      value [DEPTH];
  ooo_pkg::order_t     order [DEPTH];

  // pointers wrap with the tag width
  ooo_pkg::rob_tag_t   head;
  ooo_pkg::rob_tag_t   tail;
  logic [$bits(ooo_pkg::rob_tag_t):0] count;
  ooo_pkg::order_t     next_order;
  logic                pop;

  assign rob_full  = (count == DEPTH);
  assign alloc_tag = tail;

  // operand lookup for issue
  assign rs1_done = valid[rs1_tag] && done[rs1_tag];
  assign rs1_val  = value[rs1_tag];
  assign rs2_done = valid[rs2_tag] && done[rs2_tag];
  assign rs2_val  = value[rs2_tag];

  assign pop = valid[head] && done[head];

  always_comb begin
    commit.valid = pop;
    commit.rd    = rd[head];
    commit.value = value[head];
    commit.order = order[head];
  end
  assign commit_tag = head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid      <= '0;
      done       <= '0;
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      next_order <= '0;
    end else begin
      for (int l = 0; l < ooo_pkg::CDB_LANES; l++) begin
        if (cdb[l].valid) begin
          done[cdb[l].tag] <= 1'b1;
        end
      end
      if (rob_push) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= tail + 1'b1;
        next_order  <= next_order + 1'b1;
      end
      if (pop) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      count <= count + rob_push - pop;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < ooo_pkg::CDB_LANES; l++) begin
      if (cdb[l].valid) begin
        value[cdb[l].tag] <= cdb[l].data;
      end
    end
    if (rob_push) begin
      rd[tail]    <= push_rd;
      order[tail] <= next_order;
    end
  end

  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    rob_push |-> !rob_full);

  for (genvar l = 0; l < ooo_pkg::CDB_LANES; l++) begin : g_cdb_chk
    // a broadcast must target an entry still in flight
    a_cdb_hits_live: assert property (@(posedge clk) disable iff (!rst_n)
      cdb[l].valid |-> valid[cdb[l].tag]);
  end

endmodule : rob

`default_nettype wire

// File: logic/mul_rs.sv
`default_nettype none

module mul_rs #(
  parameter int MUL_RS_DEPTH = 2,
  parameter int MUL_LATENCY  = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mul_issue,
  input  ooo_pkg::dispatch_t disp,
  input  ooo_pkg::cdb_t      cdb [ooo_pkg::CDB_LANES],
  output logic               mul_full,
  output ooo_pkg::cdb_t      lane
);

  localparam int IW = (MUL_RS_DEPTH > 1) ? $clog2(MUL_RS_DEPTH) : 1;

  logic [MUL_RS_DEPTH-1:0] valid;
  ooo_pkg::dispatch_t      ent [MUL_RS_DEPTH];
  logic [IW-1:0]           free_idx;
  logic [IW-1:0]           sel_idx;
  logic                    sel_found;
  ooo_pkg::word_t          product;

  // multiply pipeline, one stage per cycle of latency
  logic                    pipe_valid [MUL_LATENCY];
  ooo_pkg::rob_tag_t       pipe_tag   [MUL_LATENCY];
  ooo_pkg::word_t          pipe_data  [MUL_LATENCY];

  assign mul_full = &valid;

  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = MUL_RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_idx = IW'(i);
      end
      if (valid[i] && ent[i].src1.ready && ent[i].src2.ready) begin
        sel_idx   = IW'(i);
        sel_found = 1'b1;
      end
    end
  end

  // low half only
  assign product = ent[sel_idx].src1.value * ent[sel_idx].src2.value;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
      for (int s = 0; s < MUL_LATENCY; s++) begin
        pipe_valid[s] <= 1'b0;
      end
    end else begin
      if (sel_found) begin
        valid[sel_idx] <= 1'b0;
      end
      if (mul_issue) begin
        valid[free_idx] <= 1'b1;
      end
      pipe_valid[0] <= sel_found;
      for (int s = 1; s < MUL_LATENCY; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < MUL_RS_DEPTH; i++) begin
      ent[i].src1 <= ooo_pkg::wake_operand(ent[i].src1, cdb);
      ent[i].src2 <= ooo_pkg::wake_operand(ent[i].src2, cdb);
    end
    if (mul_issue) begin
      ent[free_idx] <= disp;
    end
    pipe_tag[0]  <= ent[sel_idx].dest;
    pipe_data[0] <= product;
    for (int s = 1; s < MUL_LATENCY; s++) begin
      pipe_tag[s]  <= pipe_tag[s-1];
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  always_comb begin
    lane.valid = pipe_valid[MUL_LATENCY-1];
    lane.tag   = pipe_tag[MUL_LATENCY-1];
    lane.data  = pipe_data[MUL_LATENCY-1];
  end

  // each selected entry leaves exactly once
  a_no_repeat_tag: assert property (@(posedge clk) disable iff (!rst_n)
    lane.valid && $past(lane.valid) |-> lane.tag != $past(lane.tag));

endmodule : mul_rs

`default_nettype wire

// File: logic/alu_rs.sv
`default_nettype none

module alu_rs #(
  parameter int ALU_RS_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alu_issue,
  input  ooo_pkg::dispatch_t disp,
  input  ooo_pkg::cdb_t      cdb [ooo_pkg::CDB_LANES],
  output logic               alu_full,
  output ooo_pkg::cdb_t      lane
);

  localparam int IW = (ALU_RS_DEPTH > 1) ? $clog2(ALU_RS_DEPTH) : 1;

  logic [ALU_RS_DEPTH-1:0] valid;
  ooo_pkg::dispatch_t      ent [ALU_RS_DEPTH];
  ooo_pkg::dispatch_t      cap;
  logic [IW-1:0]           free_idx;
  logic [IW-1:0]           sel_idx;
  logic                    sel_found;

  logic                    out_valid;
  ooo_pkg::rob_tag_t       out_tag;
  ooo_pkg::word_t          out_data;

  function automatic ooo_pkg::word_t alu_fn(input ooo_pkg::alu_op_e op,
                                            input ooo_pkg::word_t a,
                                            input ooo_pkg::word_t b);
    case (op)
      ooo_pkg::ALU_ADD: return a + b;
      ooo_pkg::ALU_SUB: return a - b;
      ooo_pkg::ALU_AND: return a & b;
      ooo_pkg::ALU_OR:  return a | b;
      ooo_pkg::ALU_XOR: return a ^ b;
      ooo_pkg::ALU_SLL: return a << b[4:0];
      ooo_pkg::ALU_SRL: return a >> b[4:0];
      ooo_pkg::ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
      default:          return a + b;
    endcase
  endfunction

  assign alu_full = &valid;

  // immediate forms carry the immediate as a ready second operand
  always_comb begin
    cap = disp;
    if (disp.use_imm) begin
      cap.src2.ready = 1'b1;
      cap.src2.value = disp.imm;
    end
  end

  // lowest free slot and lowest ready entry
  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = ALU_RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_idx = IW'(i);
      end
      if (valid[i] && ent[i].src1.ready && ent[i].src2.ready) begin
        sel_idx   = IW'(i);
        sel_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (sel_found) begin
        valid[sel_idx] <= 1'b0;
      end
      if (alu_issue) begin
        valid[free_idx] <= 1'b1;
      end
      out_valid <= sel_found;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < ALU_RS_DEPTH; i++) begin
      ent[i].src1 <= ooo_pkg::wake_operand(ent[i].src1, cdb);
      ent[i].src2 <= ooo_pkg::wake_operand(ent[i].src2, cdb);
    end
    if (alu_issue) begin
      ent[free_idx] <= cap;
    end
    out_tag  <= ent[sel_idx].dest;
    out_data <= alu_fn(ent[sel_idx].op, ent[sel_idx].src1.value, ent[sel_idx].src2.value);
  end

  always_comb begin
    lane.valid = out_valid;
    lane.tag   = out_tag;
    lane.data  = out_data;
  end

  // issue must have seen the full flag
  a_no_issue_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    alu_issue |-> !alu_full);

endmodule : alu_rs

`default_nettype wire

// File: logic/issue.sv
`default_nettype none

module issue (
  input  logic             instr_valid,
  input  ooo_pkg::instr_t  instr,
  input  logic             alu_full,
  input  logic             mul_full,
  input  logic             rob_full,
  output logic             instr_stall,
  output logic             alu_issue,
  output logic             mul_issue,
  output logic             rob_push,
  output ooo_pkg::alu_op_e op,
  output logic             use_imm
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  ooo_pkg::rs_sel_e sel;
  logic             accept;

  // M extension multiply lives in OP with funct7 = 1
  assign sel = (instr.opcode == OPC_OP && instr.funct7 == 7'b0000001) ?
               ooo_pkg::RS_MUL : ooo_pkg::RS_ALU;

  assign use_imm = (instr.opcode == OPC_OP_IMM);

  always_comb begin
    case (instr.funct3)
      3'b000: begin
        op = (instr.opcode == OPC_OP && instr.funct7[5]) ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
      end
      3'b001:  op = ooo_pkg::ALU_SLL;
      3'b010:  op = ooo_pkg::ALU_SLT;
      3'b100:  op = ooo_pkg::ALU_XOR;
      3'b101:  op = ooo_pkg::ALU_SRL;
      3'b110:  op = ooo_pkg::ALU_OR;
      3'b111:  op = ooo_pkg::ALU_AND;
      default: op = ooo_pkg::ALU_ADD;
    endcase
  end

  assign instr_stall = rob_full || (sel == ooo_pkg::RS_MUL ? mul_full : alu_full);
  assign accept      = instr_valid && !instr_stall;

  assign rob_push  = accept;
  assign alu_issue = accept && (sel == ooo_pkg::RS_ALU);
  assign mul_issue = accept && (sel == ooo_pkg::RS_MUL);

endmodule : issue

`default_nettype wire

// File: logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  rob_tag_t;
  typedef logic [15:0] order_t;

  // one lane per execution unit
  localparam int CDB_LANES = 2;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_e;

  typedef enum logic {
    RS_ALU,
    RS_MUL
  } rs_sel_e;

  typedef struct packed {
    logic [6:0] opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
  } instr_t;

  typedef struct packed {
    logic     ready;
    rob_tag_t tag;
    word_t    value;
  } operand_t;

  typedef struct packed {
    alu_op_e  op;
    logic     use_imm;
    word_t    imm;
    operand_t src1;
    operand_t src2;
    rob_tag_t dest;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    data;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    value;
    order_t   order;
  } commit_t;

  // pick up a broadcast value for an operand still waiting on its tag
  function automatic operand_t wake_operand(input operand_t opnd, input cdb_t lanes [CDB_LANES]);
    operand_t res;
    res = opnd;
    for (int l = 0; l < CDB_LANES; l++) begin
      if (!res.ready && lanes[l].valid && lanes[l].tag == res.tag) begin
        res.ready = 1'b1;
        res.value = lanes[l].data;
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire
